/* verilog/soc_bus_pkg.sv */
package soc_bus_pkg;

    // Bus widths
    localparam int WORD_W = 32;
    localparam int WB_AW  = 30;
    localparam int SEL_W  = WORD_W / 8;
    localparam int LED_W  = 16;

    // On-chip RAM size in words
    localparam int RAM_AW    = 10;
    localparam int RAM_WORDS = 2 ** RAM_AW;

    // Top word-address bits that must be zero to hit the RAM
    localparam int RAM_REGION_BITS = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WB_AW-1:0]  wb_addr_t;
    typedef logic [SEL_W-1:0]  sel_t;
    typedef logic [LED_W-1:0]  led_t;
    typedef logic [RAM_AW-1:0] ram_addr_t;

    // Memory map in byte addresses
    // 0x0000_0000 .. 0x07FF_FFFF   RAM aliased on the low RAM_AW bits
    // 0xFFFF_FFE8                  switches and LEDs
    // 0xFFFF_FFF0                  timer counter
    // 0xFFFF_FFF4                  timer control
    // Word addresses of the slave registers
    localparam wb_addr_t TIMER_ADDR = 30'h3FFF_FFFC;
    localparam wb_addr_t SWLED_ADDR = 30'h3FFF_FFFA;

    // Owner of a two-master arbiter
    typedef enum logic {
        GRANT_A,
        GRANT_B
    } grant_t;

endpackage

/* verilog/wb_pri_arbiter.sv */
`timescale 1ns/1ns

module wb_pri_arbiter
    import soc_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     reset,

    // Master A, the higher priority side
    input  logic     i_a_cyc,
    input  logic     i_a_stb,
    input  logic     i_a_we,
    input  wb_addr_t i_a_adr,
    input  word_t    i_a_dat,
    input  sel_t     i_a_sel,
    output logic     o_a_ack,
    output logic     o_a_stall,
    output logic     o_a_err,

    // Master B
    input  logic     i_b_cyc,
    input  logic     i_b_stb,
    input  logic     i_b_we,
    input  wb_addr_t i_b_adr,
    input  word_t    i_b_dat,
    input  sel_t     i_b_sel,
    output logic     o_b_ack,
    output logic     o_b_stall,
    output logic     o_b_err,

    // Merged bus toward the slaves
    output logic     o_cyc,
    output logic     o_stb,
    output logic     o_we,
    output wb_addr_t o_adr,
    output word_t    o_dat,
    output sel_t     o_sel,
    input  logic     i_ack,
    input  logic     i_stall,
    input  logic     i_err
);

    grant_t owner;
    grant_t grant;
    logic   owner_cyc;
    logic   a_granted;

    assign owner_cyc = (owner == GRANT_A) ? i_a_cyc : i_b_cyc;

    // An open cycle keeps the bus, otherwise A wins
    always_comb begin
        if (owner_cyc) begin
            grant = owner;
        end else if (i_a_cyc || !i_b_cyc) begin
            grant = GRANT_A;
        end else begin
            grant = GRANT_B;
        end
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            owner <= GRANT_A;
        end else begin
            owner <= grant;
        end
    end

    assign a_granted = (grant == GRANT_A);

    assign o_cyc = a_granted ? i_a_cyc : i_b_cyc;
    assign o_stb = a_granted ? i_a_stb : i_b_stb;
    assign o_we  = a_granted ? i_a_we  : i_b_we;
    assign o_adr = a_granted ? i_a_adr : i_b_adr;
    assign o_dat = a_granted ? i_a_dat : i_b_dat;
    assign o_sel = a_granted ? i_a_sel : i_b_sel;

    // Responses only go to the owner
    assign o_a_ack = a_granted && i_ack;
    assign o_b_ack = !a_granted && i_ack;
    assign o_a_err = a_granted && i_err;
    assign o_b_err = !a_granted && i_err;

    // The loser is held off on every strobe
    assign o_a_stall = a_granted ? i_stall : i_a_stb;
    assign o_b_stall = a_granted ? i_b_stb : i_stall;

    a_single_ack: assert property (@(posedge i_clk) disable iff (reset)
        !(o_a_ack && o_b_ack));

    // A response arriving after its master closed the cycle means lost ownership
    a_resp_in_cycle: assert property (@(posedge i_clk) disable iff (reset)
        ((o_a_ack || o_a_err) |-> i_a_cyc) and ((o_b_ack || o_b_err) |-> i_b_cyc));

endmodule

/* verilog/bus_decoder.sv */
`timescale 1ns/1ns

module bus_decoder
    import soc_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     reset,
    input  logic     i_stb,
    input  wb_addr_t i_adr,

    // Slave responses
    input  logic     i_ram_ack,
    input  logic     i_tmr_ack,
    input  logic     i_swled_ack,
    input  word_t    i_ram_dat,
    input  word_t    i_tmr_dat,
    input  word_t    i_swled_dat,

    // Slave strobes
    output logic     o_ram_stb,
    output logic     o_tmr_stb,
    output logic     o_swled_stb,

    // Back to the main arbiter
    output logic     o_ack,
    output logic     o_err,
    output logic     o_stall,
    output word_t    o_dat,
    output word_t    o_err_addr
);

    logic ram_sel;
    logic tmr_sel;
    logic swled_sel;
    logic none_sel;

    // RAM sits at the bottom of the space
    assign ram_sel   = (i_adr[WB_AW-1 -: RAM_REGION_BITS] == '0);
    // Timer covers a pair of words, bit 0 picks the register
    assign tmr_sel   = (i_adr[WB_AW-1:1] == TIMER_ADDR[WB_AW-1:1]);
    assign swled_sel = (i_adr == SWLED_ADDR);
    assign none_sel  = !ram_sel && !tmr_sel && !swled_sel;

    assign o_ram_stb   = i_stb && ram_sel;
    assign o_tmr_stb   = i_stb && tmr_sel;
    assign o_swled_stb = i_stb && swled_sel;

    // None of the mapped slaves ever back-pressures
    assign o_stall = 1'b0;

    // Unmapped access, flagged one cycle later
    always_ff @(posedge i_clk) begin
        if (reset) begin
            o_err      <= 1'b0;
            o_err_addr <= '0;
        end else begin
            o_err <= i_stb && none_sel;
            if (i_stb && none_sel) begin
                o_err_addr <= {i_adr, 2'b00};
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_ram_ack || i_tmr_ack || i_swled_ack;
        end
    end

    // Return data, RAM first
    always_ff @(posedge i_clk) begin
        if (i_ram_ack) begin
            o_dat <= i_ram_dat;
        end else if (i_tmr_ack) begin
            o_dat <= i_tmr_dat;
        end else if (i_swled_ack) begin
            o_dat <= i_swled_dat;
        end else begin
            o_dat <= '0;
        end
    end

    a_one_select: assert property (@(posedge i_clk) disable iff (reset)
        $onehot0({o_ram_stb, o_tmr_stb, o_swled_stb}));

    // Slave ack plus the return register give a fixed two-cycle turnaround
    a_mapped_ack: assert property (@(posedge i_clk) disable iff (reset)
        (i_stb && !none_sel) |-> ##2 o_ack);

endmodule

/* verilog/bus_ram.sv */
`timescale 1ns/1ns

module bus_ram
    import soc_bus_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_stb,
    input  logic      i_we,
    input  ram_addr_t i_adr,
    input  word_t     i_dat,
    input  sel_t      i_sel,
    output logic      o_ack,
    output word_t     o_dat
);

    word_t mem [RAM_WORDS];

    // Byte-lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_we) begin
            for (int lane = 0; lane < SEL_W; lane++) begin
                if (i_sel[lane]) begin
                    mem[i_adr][lane*8 +: 8] <= i_dat[lane*8 +: 8];
                end
            end
        end
    end

    // Registered read, old data on a same-cycle write
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_dat <= mem[i_adr];
        end
    end

    always_ff @(posedge i_clk) begin
        o_ack <= i_stb;
    end

endmodule

/* verilog/bus_timer.sv */
`timescale 1ns/1ns

module bus_timer
    import soc_bus_pkg::*;
(
    input  logic  i_clk,
    input  logic  reset,
    input  logic  i_stb,
    input  logic  i_we,
    input  logic  i_reg,
    input  word_t i_dat,
    output logic  o_ack,
    output word_t o_dat
);

    word_t count;
    logic  enable;

    always_ff @(posedge i_clk) begin
        if (reset) begin
            count  <= '0;
            enable <= 1'b0;
            o_ack  <= 1'b0;
        end else begin
            o_ack <= i_stb;

            // A counter write wins over the increment
            if (i_stb && i_we && !i_reg) begin
                count <= i_dat;
            end else if (enable) begin
                count <= count + 1'b1;
            end

            if (i_stb && i_we && i_reg) begin
                enable <= i_dat[0];
            end
        end
    end

    // Word 0 is the count, word 1 the control
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_dat <= i_reg ? {{(WORD_W-1){1'b0}}, enable} : count;
        end
    end

endmodule

/* verilog/bus_switch_led.sv */
`timescale 1ns/1ns

module bus_switch_led
    import soc_bus_pkg::*;
(
    input  logic  i_clk,
    input  logic  reset,
    input  logic  i_stb,
    input  logic  i_we,
    input  word_t i_dat,
    input  sel_t  i_sel,
    input  led_t  i_switches,
    output logic  o_ack,
    output word_t o_dat,
    output led_t  o_leds
);

    always_ff @(posedge i_clk) begin
        if (reset) begin
            o_leds <= '0;
            o_ack  <= 1'b0;
        end else begin
            o_ack <= i_stb;
            // LEDs live in the two low byte lanes
            if (i_stb && i_we) begin
                for (int lane = 0; lane < LED_W / 8; lane++) begin
                    if (i_sel[lane]) begin
                        o_leds[lane*8 +: 8] <= i_dat[lane*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_dat <= {i_switches, o_leds};
        end
    end

endmodule

/* verilog/soc_bus_top.sv */
`timescale 1ns/1ns

module soc_bus_top
    import soc_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     reset,

    // Data fetch master
    input  logic     i_dmst_cyc,
    input  logic     i_dmst_stb,
    input  logic     i_dmst_we,
    input  wb_addr_t i_dmst_adr,
    input  word_t    i_dmst_dat,
    input  sel_t     i_dmst_sel,
    output logic     o_dmst_ack,
    output logic     o_dmst_stall,
    output logic     o_dmst_err,

    // Instruction fetch master
    input  logic     i_imst_cyc,
    input  logic     i_imst_stb,
    input  logic     i_imst_we,
    input  wb_addr_t i_imst_adr,
    input  word_t    i_imst_dat,
    input  sel_t     i_imst_sel,
    output logic     o_imst_ack,
    output logic     o_imst_stall,
    output logic     o_imst_err,

    // Debug master
    input  logic     i_dbg_cyc,
    input  logic     i_dbg_stb,
    input  logic     i_dbg_we,
    input  wb_addr_t i_dbg_adr,
    input  word_t    i_dbg_dat,
    input  sel_t     i_dbg_sel,
    output logic     o_dbg_ack,
    output logic     o_dbg_stall,
    output logic     o_dbg_err,

    input  led_t     i_switches,
    output word_t    o_rdata,
    output word_t    o_err_addr,
    output led_t     o_leds
);

    // Internal bus, data and instruction fetch merged
    logic     ibus_cyc, ibus_stb, ibus_we;
    wb_addr_t ibus_adr;
    word_t    ibus_dat;
    sel_t     ibus_sel;
    logic     ibus_ack, ibus_stall, ibus_err;

    // Main bus
    logic     mbus_cyc, mbus_stb, mbus_we;
    wb_addr_t mbus_adr;
    word_t    mbus_dat;
    sel_t     mbus_sel;
    logic     mbus_ack, mbus_stall, mbus_err;

    // Slave side
    logic     ram_stb, tmr_stb, swled_stb;
    logic     ram_ack, tmr_ack, swled_ack;
    word_t    ram_dat, tmr_dat, swled_dat;

    wb_pri_arbiter u_ibus_arb (
        .i_clk(i_clk), .reset(reset),
        .i_a_cyc(i_dmst_cyc), .i_a_stb(i_dmst_stb), .i_a_we(i_dmst_we),
        .i_a_adr(i_dmst_adr), .i_a_dat(i_dmst_dat), .i_a_sel(i_dmst_sel),
        .o_a_ack(o_dmst_ack), .o_a_stall(o_dmst_stall), .o_a_err(o_dmst_err),
        .i_b_cyc(i_imst_cyc), .i_b_stb(i_imst_stb), .i_b_we(i_imst_we),
        .i_b_adr(i_imst_adr), .i_b_dat(i_imst_dat), .i_b_sel(i_imst_sel),
        .o_b_ack(o_imst_ack), .o_b_stall(o_imst_stall), .o_b_err(o_imst_err),
        .o_cyc(ibus_cyc), .o_stb(ibus_stb), .o_we(ibus_we),
        .o_adr(ibus_adr), .o_dat(ibus_dat), .o_sel(ibus_sel),
        .i_ack(ibus_ack), .i_stall(ibus_stall), .i_err(ibus_err)
    );

    // Internal bus has priority over debug
    wb_pri_arbiter u_mbus_arb (
        .i_clk(i_clk), .reset(reset),
        .i_a_cyc(ibus_cyc), .i_a_stb(ibus_stb), .i_a_we(ibus_we),
        .i_a_adr(ibus_adr), .i_a_dat(ibus_dat), .i_a_sel(ibus_sel),
        .o_a_ack(ibus_ack), .o_a_stall(ibus_stall), .o_a_err(ibus_err),
        .i_b_cyc(i_dbg_cyc), .i_b_stb(i_dbg_stb), .i_b_we(i_dbg_we),
        .i_b_adr(i_dbg_adr), .i_b_dat(i_dbg_dat), .i_b_sel(i_dbg_sel),
        .o_b_ack(o_dbg_ack), .o_b_stall(o_dbg_stall), .o_b_err(o_dbg_err),
        .o_cyc(mbus_cyc), .o_stb(mbus_stb), .o_we(mbus_we),
        .o_adr(mbus_adr), .o_dat(mbus_dat), .o_sel(mbus_sel),
        .i_ack(mbus_ack), .i_stall(mbus_stall), .i_err(mbus_err)
    );

    // Read data goes back to every master unarbitrated
    bus_decoder u_decoder (
        .i_clk(i_clk), .reset(reset),
        .i_stb(mbus_cyc && mbus_stb), .i_adr(mbus_adr),
        .i_ram_ack(ram_ack), .i_tmr_ack(tmr_ack), .i_swled_ack(swled_ack),
        .i_ram_dat(ram_dat), .i_tmr_dat(tmr_dat), .i_swled_dat(swled_dat),
        .o_ram_stb(ram_stb), .o_tmr_stb(tmr_stb), .o_swled_stb(swled_stb),
        .o_ack(mbus_ack), .o_err(mbus_err), .o_stall(mbus_stall),
        .o_dat(o_rdata), .o_err_addr(o_err_addr)
    );

    bus_ram u_ram (
        .i_clk(i_clk), .i_stb(ram_stb), .i_we(mbus_we),
        .i_adr(mbus_adr[RAM_AW-1:0]), .i_dat(mbus_dat), .i_sel(mbus_sel),
        .o_ack(ram_ack), .o_dat(ram_dat)
    );

    bus_timer u_timer (
        .i_clk(i_clk), .reset(reset), .i_stb(tmr_stb), .i_we(mbus_we),
        .i_reg(mbus_adr[0]), .i_dat(mbus_dat),
        .o_ack(tmr_ack), .o_dat(tmr_dat)
    );

    bus_switch_led u_swled (
        .i_clk(i_clk), .reset(reset), .i_stb(swled_stb), .i_we(mbus_we),
        .i_dat(mbus_dat), .i_sel(mbus_sel), .i_switches(i_switches),
        .o_ack(swled_ack), .o_dat(swled_dat), .o_leds(o_leds)
    );

endmodule

/* sim/tb_soc_bus.sv */
`timescale 1ns/1ns

module tb_soc_bus
    import soc_bus_pkg::*;
();

    localparam int TIMEOUT = 40;
    localparam int NWORDS  = 12;

    logic       i_clk;
    logic       reset;
    logic [2:0] cyc, stb, we;
    wb_addr_t   adr [3];
    word_t      wdat [3];
    sel_t       sel [3];
    wire  [2:0] ack, stall, err;
    led_t       switches;
    word_t      rdata;
    word_t      err_addr;
    led_t       leds;

    // Last response seen by each master (0 dmst, 1 imst, 2 dbg)
    word_t r_data [3];
    logic  r_ack [3];
    logic  r_err [3];
    logic  r_extra [3];
    int    r_lat [3];
    int    r_wait [3];
    time   r_accept [3];
    time   r_done [3];

    // Reference model
    word_t ram_model [RAM_WORDS];
    led_t  led_model;
    word_t tmr_count;
    logic  tmr_enable;
    word_t err_addr_model;

    soc_bus_top u_dut (
        .i_clk(i_clk), .reset(reset),
        .i_dmst_cyc(cyc[0]), .i_dmst_stb(stb[0]), .i_dmst_we(we[0]),
        .i_dmst_adr(adr[0]), .i_dmst_dat(wdat[0]), .i_dmst_sel(sel[0]),
        .o_dmst_ack(ack[0]), .o_dmst_stall(stall[0]), .o_dmst_err(err[0]),
        .i_imst_cyc(cyc[1]), .i_imst_stb(stb[1]), .i_imst_we(we[1]),
        .i_imst_adr(adr[1]), .i_imst_dat(wdat[1]), .i_imst_sel(sel[1]),
        .o_imst_ack(ack[1]), .o_imst_stall(stall[1]), .o_imst_err(err[1]),
        .i_dbg_cyc(cyc[2]), .i_dbg_stb(stb[2]), .i_dbg_we(we[2]),
        .i_dbg_adr(adr[2]), .i_dbg_dat(wdat[2]), .i_dbg_sel(sel[2]),
        .o_dbg_ack(ack[2]), .o_dbg_stall(stall[2]), .o_dbg_err(err[2]),
        .i_switches(switches), .o_rdata(rdata), .o_err_addr(err_addr), .o_leds(leds)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_led(input string name, input led_t exp, input led_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic word_t merge_lanes(input word_t old, input word_t d, input sel_t s);
        word_t res;
        res = old;
        for (int lane = 0; lane < SEL_W; lane++) begin
            if (s[lane]) begin
                res[lane*8 +: 8] = d[lane*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic is_mapped(input wb_addr_t a);
        return (a[WB_AW-1 -: RAM_REGION_BITS] == '0) ||
               (a[WB_AW-1:1] == TIMER_ADDR[WB_AW-1:1]) || (a == SWLED_ADDR);
    endfunction

    // One request driven and released 1 ns after a rising edge
    // Outputs are sampled 3 ns after the edge
    task automatic master_access(input int m, input logic w, input wb_addr_t a,
                                 input word_t d, input sel_t s);
        cyc[m]  = 1'b1;
        stb[m]  = 1'b1;
        we[m]   = w;
        adr[m]  = a;
        wdat[m] = d;
        sel[m]  = s;
        r_wait[m] = 0;
        #2;
        while (stall[m]) begin
            r_wait[m]++;
            if (r_wait[m] > TIMEOUT) begin
                abort_run($sformatf("Master %0d was never granted the bus", m));
            end
            @(posedge i_clk);
            #3;
        end
        @(posedge i_clk);
        r_accept[m] = $time;
        #1;
        stb[m] = 1'b0;
        we[m]  = 1'b0;
        r_lat[m] = 1;
        #2;
        while (!ack[m] && !err[m]) begin
            r_lat[m]++;
            if (r_lat[m] > TIMEOUT) begin
                abort_run($sformatf("Master %0d got neither ack nor err", m));
            end
            @(posedge i_clk);
            #3;
        end
        r_ack[m]  = ack[m];
        r_err[m]  = err[m];
        r_data[m] = rdata;
        // One more cycle with cyc high to catch a stray ack
        @(posedge i_clk);
        #3;
        r_extra[m] = ack[m];
        @(posedge i_clk);
        r_done[m] = $time;
        #1;
        cyc[m] = 1'b0;
    endtask

    task automatic expect_mapped(input string name, input int m);
        check_flag({name, " ack"}, 1'b1, r_ack[m]);
        check_flag({name, " err"}, 1'b0, r_err[m]);
        check_word({name, " latency"}, word_t'(2), word_t'(r_lat[m]));
        check_flag({name, " single ack"}, 1'b0, r_extra[m]);
    endtask

    task automatic write_word(input string name, input int m, input wb_addr_t a,
                              input word_t d, input sel_t s);
        master_access(m, 1'b1, a, d, s);
        expect_mapped(name, m);
    endtask

    task automatic read_check(input string name, input int m, input wb_addr_t a,
                              input word_t exp);
        master_access(m, 1'b0, a, '0, 4'hF);
        expect_mapped(name, m);
        check_word(name, exp, r_data[m]);
    endtask

    task automatic timer_counting();
        word_t cnt;
        read_check("timer count after reset", 0, TIMER_ADDR, tmr_count);
        read_check("timer ctrl after reset", 2, TIMER_ADDR | 30'h1, {31'b0, tmr_enable});
        cnt = $urandom & 32'h7FFF_FFFF;
        tmr_count = cnt;
        write_word("timer load", 2, TIMER_ADDR, cnt, 4'hF);
        read_check("timer hold", 1, TIMER_ADDR, tmr_count);
        tmr_enable = 1'b1;
        write_word("timer enable", 0, TIMER_ADDR | 30'h1, 32'h1, 4'hF);
        read_check("timer ctrl", 0, TIMER_ADDR | 30'h1, {31'b0, tmr_enable});
        tmr_enable = 1'b0;
        write_word("timer disable", 1, TIMER_ADDR | 30'h1, 32'h0, 4'hF);
        master_access(0, 1'b0, TIMER_ADDR, '0, 4'hF);
        expect_mapped("timer count", 0);
        check_flag("timer advanced", 1'b1, r_data[0] > tmr_count);
    endtask

    task automatic ram_lane_writes();
        wb_addr_t addrs [NWORDS];
        word_t    d;
        sel_t     s;
        // Full words first so later partial writes never leave undefined lanes
        for (int i = 0; i < NWORDS; i++) begin
            addrs[i] = {5'b0, 15'($urandom), 10'($urandom)};
            d = $urandom;
            write_word("ram fill", $urandom_range(2, 0), addrs[i], d, 4'hF);
            ram_model[addrs[i][RAM_AW-1:0]] = d;
        end
        for (int i = 0; i < NWORDS; i++) begin
            d = $urandom;
            s = 4'($urandom);
            write_word("ram lane write", $urandom_range(2, 0), addrs[i], d, s);
            ram_model[addrs[i][RAM_AW-1:0]] = merge_lanes(ram_model[addrs[i][RAM_AW-1:0]], d, s);
        end
        for (int i = 0; i < NWORDS; i++) begin
            read_check("ram read", $urandom_range(2, 0), addrs[i],
                       ram_model[addrs[i][RAM_AW-1:0]]);
        end
    endtask

    task automatic unmapped_errors();
        wb_addr_t a;
        int       m;
        for (int i = 0; i < 6; i++) begin
            a = 30'($urandom);
            while (is_mapped(a)) begin
                a = 30'($urandom);
            end
            m = $urandom_range(2, 0);
            master_access(m, 1'($urandom), a, $urandom, 4'($urandom));
            err_addr_model = {a, 2'b00};
            check_flag("unmapped err", 1'b1, r_err[m]);
            check_flag("unmapped ack", 1'b0, r_ack[m]);
            check_word("unmapped latency", word_t'(1), word_t'(r_lat[m]));
            check_flag("unmapped late ack", 1'b0, r_extra[m]);
            check_word("error address", err_addr_model, err_addr);
        end
    endtask

    task automatic led_register();
        word_t d;
        sel_t  s;
        word_t merged;
        for (int i = 0; i < 6; i++) begin
            d = $urandom;
            s = 4'($urandom);
            write_word("led write", $urandom_range(2, 0), SWLED_ADDR, d, s);
            merged = merge_lanes({16'h0, led_model}, d, s);
            led_model = merged[LED_W-1:0];
            check_led("leds", led_model, leds);
        end
        switches = 16'($urandom);
        read_check("switch led read", $urandom_range(2, 0), SWLED_ADDR, {switches, led_model});
    endtask

    task automatic arbitration_order();
        word_t d;
        d = $urandom;
        // An idle cycle hands the internal bus back to data fetch
        @(posedge i_clk);
        #1;
        // Data fetch must win when both start in the same cycle
        fork
            master_access(0, 1'b1, 30'h5, d, 4'hF);
            master_access(1, 1'b0, 30'h5, '0, 4'hF);
        join
        ram_model[5] = d;
        expect_mapped("dmst first", 0);
        expect_mapped("imst second", 1);
        check_word("dmst stall cycles", '0, word_t'(r_wait[0]));
        check_flag("imst stalled", 1'b1, r_wait[1] > 0);
        check_flag("imst waits for dmst cyc", 1'b1, r_done[0] < r_accept[1]);
        check_word("imst read after dmst write", ram_model[5], r_data[1]);
        fork
            master_access(0, 1'b0, 30'h5, '0, 4'hF);
            begin
                @(posedge i_clk);
                #1;
                master_access(2, 1'b0, SWLED_ADDR, '0, 4'hF);
            end
        join
        expect_mapped("dmst during dbg", 0);
        expect_mapped("dbg after ibus", 2);
        check_flag("dbg waits for ibus cycle", 1'b1, r_done[0] < r_accept[2]);
        check_word("dbg read", {switches, led_model}, r_data[2]);
    endtask

    initial begin
        void'($urandom(32'h7a9c_20eb));
        cyc = '0;
        stb = '0;
        we  = '0;
        for (int i = 0; i < 3; i++) begin
            adr[i]  = '0;
            wdat[i] = '0;
            sel[i]  = '0;
        end
        switches       = '0;
        led_model      = '0;
        tmr_count      = '0;
        tmr_enable     = 1'b0;
        err_addr_model = '0;
        reset = 1'b1;
        repeat (3) @(posedge i_clk);
        #1;
        reset = 1'b0;
        check_flag("ack after reset", 1'b0, |ack);
        check_flag("err after reset", 1'b0, |err);
        check_word("error address after reset", err_addr_model, err_addr);
        check_led("leds after reset", led_model, leds);
        timer_counting();
        ram_lane_writes();
        unmapped_errors();
        led_register();
        arbitration_order();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* project.f */
verilog/soc_bus_pkg.sv
verilog/wb_pri_arbiter.sv
verilog/bus_decoder.sv
verilog/bus_ram.sv
verilog/bus_timer.sv
verilog/bus_switch_led.sv
verilog/soc_bus_top.sv
sim/tb_soc_bus.sv

/* Bender.yml */
package:
  name: soc_bus

sources:
  - verilog/soc_bus_pkg.sv
  - verilog/wb_pri_arbiter.sv
  - verilog/bus_decoder.sv
  - verilog/bus_ram.sv
  - verilog/bus_timer.sv
  - verilog/bus_switch_led.sv
  - verilog/soc_bus_top.sv
  - target: simulation
    files:
      - sim/tb_soc_bus.sv
